// File: Bender.yml
package:
  name: rs_core

sources:
  # Core RTL, package first
  - files:
      - design/rs_core_pkg.sv
      - design/pc_unit.sv
      - design/instr_decoder.sv
      - design/reg_bank.sv
      - design/alu_unit.sv
      - design/core_control.sv
      - design/rs_core_top.sv
  # Testbench with its program image header
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_core.sv

// File: design/alu_unit.sv
// ALU of the core, also giving the branch decision and the PC-relative target
`timescale 1ns/10ps

module alu_unit
  import rs_core_pkg::*;
(
  input  alu_op_e      op_i,
  input  instr_class_e instr_class_i,
  input  word_t        a_i,
  input  word_t        b_i,
  input  word_t        imm_i,
  input  word_t        pc_i,
  input  logic         use_imm_i,
  output word_t        result_o,
  output word_t        target_o,
  output logic         branch_taken_o
);

  word_t operand_b;
  logic  result_zero;

  // Immediate replaces rs2 for ADDI, LUI, loads and stores
  assign operand_b = use_imm_i ? imm_i : b_i;

  always_comb begin
    case (op_i)
      ALU_ADD: result_o = a_i + operand_b;
      ALU_SUB: result_o = a_i - operand_b;
      ALU_AND: result_o = a_i & operand_b;
      ALU_OR:  result_o = a_i | operand_b;
      ALU_XOR: result_o = a_i ^ operand_b;
      default: result_o = operand_b;
    endcase
  end

  // Zero after SUB or XOR means the operands are equal
  assign result_zero = (result_o == '0);

  // BEQ takes on zero, BNE on nonzero
  assign branch_taken_o = (instr_class_i == CLASS_BRANCH)
                        && (result_zero ^ (op_i == ALU_XOR));

  // Branch and JAL target
  assign target_o = pc_i + imm_i;

endmodule

// File: design/core_control.sv
// Multicycle control FSM that sequences fetch, execute, memory and interrupt entry
`timescale 1ns/10ps

module core_control
  import rs_core_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n_i,
  input  logic         stall_i,
  input  logic         irq_i,
  input  instr_class_e instr_class_i,
  input  logic         branch_taken_i,
  output logic         latch_instr_o,
  output logic         pc_advance_o,
  output logic         pc_jump_o,
  output logic         pc_trap_o,
  output logic         pc_return_o,
  output logic         reg_write_o,
  output logic [1:0]   wb_sel_o,
  output logic         mem_operation_enable_o,
  output byte_en_t     mem_write_enable_o,
  output logic         interrupt_ack_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        handler_active_q;
  logic        reg_write;

  ////////////////////////////////////////
  // Next state and commands
  ////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    latch_instr_o = 1'b0;
    pc_advance_o  = 1'b0;
    pc_jump_o     = 1'b0;
    pc_trap_o     = 1'b0;
    pc_return_o   = 1'b0;
    reg_write     = 1'b0;
    wb_sel_o      = WB_ALU;
    case (state_q)
      // Interrupt only between instructions, never nested
      S_FETCH: begin
        if (irq_i && !handler_active_q) begin
          state_d = S_TRAP;
        end else begin
          latch_instr_o = !stall_i;
          state_d       = S_EXECUTE;
        end
      end
      S_EXECUTE: begin
        state_d = S_FETCH;
        case (instr_class_i)
          CLASS_ALU_REG, CLASS_ALU_IMM, CLASS_LUI: begin
            reg_write    = 1'b1;
            pc_advance_o = 1'b1;
          end
          CLASS_LOAD, CLASS_STORE: state_d = S_MEMORY;
          CLASS_BRANCH: begin
            pc_jump_o    = branch_taken_i;
            pc_advance_o = !branch_taken_i;
          end
          // Link written while the PC still holds the JAL address
          CLASS_JAL: begin
            reg_write = 1'b1;
            wb_sel_o  = WB_LINK;
            pc_jump_o = 1'b1;
          end
          CLASS_MRET: pc_return_o = 1'b1;
          default: pc_advance_o = 1'b1;
        endcase
      end
      // Load data written back at the end of this cycle
      S_MEMORY: begin
        state_d      = S_FETCH;
        pc_advance_o = 1'b1;
        if (instr_class_i == CLASS_LOAD) begin
          reg_write = 1'b1;
          wb_sel_o  = WB_LOAD;
        end
      end
      default: begin
        state_d   = S_FETCH;
        pc_trap_o = 1'b1;
      end
    endcase
  end

  assign reg_write_o = reg_write && !stall_i;

  ////////////////////////////////////////
  // Strobes
  ////////////////////////////////////////

  // Level strobes follow the state and so hold through a stall
  assign mem_operation_enable_o = (state_q == S_MEMORY);
  assign mem_write_enable_o = {4{(state_q == S_MEMORY) && (instr_class_i == CLASS_STORE)}};

  // Ack once, on the cycle TRAP is left
  assign interrupt_ack_o = (state_q == S_TRAP) && !stall_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q          <= S_FETCH;
      handler_active_q <= 1'b0;
    end else if (!stall_i) begin
      state_q <= state_d;
      if (pc_trap_o) begin
        handler_active_q <= 1'b1;
      end else if (pc_return_o) begin
        handler_active_q <= 1'b0;
      end
    end
  end

  a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
    interrupt_ack_o |=> !interrupt_ack_o);

  // Memory access only for a load or store, entered from EXECUTE
  a_mem_in_memory: assert property (@(posedge clk) disable iff (!rst_n_i)
    (mem_operation_enable_o || mem_write_enable_o != '0)
      |-> (instr_class_i inside {CLASS_LOAD, CLASS_STORE})
          && ($past(state_q) inside {S_EXECUTE, S_MEMORY}));

endmodule

// File: design/instr_decoder.sv
// Instruction register and combinational decode into indices, immediate, ALU op and class
`timescale 1ns/10ps

module instr_decoder
  import rs_core_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n_i,
  input  logic         latch_i,
  input  word_t        instruction_i,
  output reg_idx_t     rs1_o,
  output reg_idx_t     rs2_o,
  output reg_idx_t     rd_o,
  output word_t        imm_o,
  output alu_op_e      alu_op_o,
  output instr_class_e instr_class_o,
  output logic         use_imm_o
);

  word_t      instr_q;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i_type;
  word_t      imm_s_type;
  word_t      imm_b_type;
  word_t      imm_u_type;
  word_t      imm_j_type;

  // All-zero word decodes as a no-op
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      instr_q <= '0;
    end else if (latch_i) begin
      instr_q <= instruction_i;
    end
  end

  ////////////////////////////////////////
  // Fields and immediates
  ////////////////////////////////////////

  assign opcode = instr_q[6:0];
  assign funct3 = instr_q[14:12];
  assign funct7 = instr_q[31:25];
  assign rs1_o  = instr_q[19:15];
  assign rs2_o  = instr_q[24:20];
  assign rd_o   = instr_q[11:7];

  assign imm_i_type = {{20{instr_q[31]}}, instr_q[31:20]};
  assign imm_s_type = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
  assign imm_b_type = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                       instr_q[11:8], 1'b0};
  assign imm_u_type = {instr_q[31:12], 12'b0};
  assign imm_j_type = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                       instr_q[30:21], 1'b0};

  ////////////////////////////////////////
  // Class and operation
  ////////////////////////////////////////

  always_comb begin
    instr_class_o = CLASS_NOP;
    alu_op_o      = ALU_ADD;
    imm_o         = imm_i_type;
    use_imm_o     = 1'b0;
    case (opcode)
      OPC_OP: begin
        instr_class_o = CLASS_ALU_REG;
        if (funct7 == 7'h20 && funct3 == 3'b000) begin
          alu_op_o = ALU_SUB;
        end else if (funct7 != 7'h00) begin
          instr_class_o = CLASS_NOP;
        end else begin
          case (funct3)
            3'b000:  alu_op_o = ALU_ADD;
            3'b111:  alu_op_o = ALU_AND;
            3'b110:  alu_op_o = ALU_OR;
            3'b100:  alu_op_o = ALU_XOR;
            default: instr_class_o = CLASS_NOP;
          endcase
        end
      end
      // ADDI only
      OPC_OP_IMM: begin
        use_imm_o = 1'b1;
        if (funct3 == 3'b000) begin
          instr_class_o = CLASS_ALU_IMM;
        end
      end
      OPC_LUI: begin
        instr_class_o = CLASS_LUI;
        alu_op_o      = ALU_PASS_B;
        imm_o         = imm_u_type;
        use_imm_o     = 1'b1;
      end
      // Word access, address is rs1 plus offset
      OPC_LOAD: begin
        use_imm_o = 1'b1;
        if (funct3 == 3'b010) begin
          instr_class_o = CLASS_LOAD;
        end
      end
      OPC_STORE: begin
        imm_o     = imm_s_type;
        use_imm_o = 1'b1;
        if (funct3 == 3'b010) begin
          instr_class_o = CLASS_STORE;
        end
      end
      // Branch sense rides on the op: SUB for BEQ, XOR for BNE
      OPC_BRANCH: begin
        imm_o    = imm_b_type;
        alu_op_o = funct3[0] ? ALU_XOR : ALU_SUB;
        if (funct3[2:1] == 2'b00) begin
          instr_class_o = CLASS_BRANCH;
        end
      end
      OPC_JAL: begin
        instr_class_o = CLASS_JAL;
        imm_o         = imm_j_type;
      end
      OPC_SYSTEM: begin
        if (instr_q == INSTR_MRET) begin
          instr_class_o = CLASS_MRET;
        end
      end
      default: instr_class_o = CLASS_NOP;
    endcase
  end

endmodule

// File: design/pc_unit.sv
// Program counter of the core, stepped by one command per retirement from the control FSM
`timescale 1ns/10ps

module pc_unit
  import rs_core_pkg::*;
#(
  parameter word_t RESET_VECTOR = 32'h0000_0000,
  parameter word_t TRAP_VECTOR  = 32'h0000_0100
) (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  stall_i,
  input  logic  advance_i,
  input  logic  jump_i,
  input  logic  trap_i,
  input  logic  return_i,
  input  word_t target_i,
  output word_t pc_o,
  output word_t link_o
);

  word_t pc_q;
  word_t epc_q;

  // Sequential successor, also the JAL link value
  assign link_o = pc_q + 32'd4;
  assign pc_o   = pc_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= RESET_VECTOR;
    end else if (!stall_i) begin
      if (advance_i) begin
        pc_q <= link_o;
      end else if (jump_i) begin
        pc_q <= target_i;
      end else if (trap_i) begin
        pc_q <= TRAP_VECTOR;
      end else if (return_i) begin
        pc_q <= epc_q;
      end
    end
  end

  // Return address, the instruction that was not fetched
  always_ff @(posedge clk) begin
    if (!stall_i && trap_i) begin
      epc_q <= pc_q;
    end
  end

  // Control never issues two PC commands at once
  a_one_command: assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0({advance_i, jump_i, trap_i, return_i}));

endmodule

// File: design/reg_bank.sv
// Integer register file with two asynchronous read ports and one write port, x0 tied to zero
`timescale 1ns/10ps

module reg_bank
  import rs_core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     write_i,
  input  reg_idx_t rs1_i,
  input  reg_idx_t rs2_i,
  input  reg_idx_t rd_i,
  input  word_t    data_i,
  output word_t    data1_o,
  output word_t    data2_o
);

  // No storage behind x0
  word_t regs_q [1:31];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (write_i && rd_i != '0) begin
      regs_q[rd_i] <= data_i;
    end
  end

  // Reads of x0 return zero
  assign data1_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
  assign data2_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

// File: design/rs_core_pkg.sv
// Widths, types and opcode encodings that every core module takes in with a wildcard import
package rs_core_pkg;

  // Data and address width
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [3:0]      byte_en_t;

  // ALU operations of the kept subset
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  // Instruction classes seen by the control FSM
  typedef enum logic [3:0] {
    CLASS_ALU_REG,
    CLASS_ALU_IMM,
    CLASS_LUI,
    CLASS_LOAD,
    CLASS_STORE,
    CLASS_BRANCH,
    CLASS_JAL,
    CLASS_MRET,
    CLASS_NOP
  } instr_class_e;

  // Control FSM states
  typedef enum logic [1:0] {
    S_FETCH,
    S_EXECUTE,
    S_MEMORY,
    S_TRAP
  } ctrl_state_e;

  // RISC-V major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // Full MRET encoding
  localparam word_t INSTR_MRET = 32'h30200073;

  // Register write-back sources
  localparam logic [1:0] WB_ALU  = 2'd0;
  localparam logic [1:0] WB_LOAD = 2'd1;
  localparam logic [1:0] WB_LINK = 2'd2;

endpackage

// File: design/rs_core_top.sv
// Top level of the multicycle core, wiring its five blocks to the instruction and data ports
`timescale 1ns/10ps

module rs_core_top
  import rs_core_pkg::*;
#(
  parameter word_t RESET_VECTOR = 32'h0000_0000,
  parameter word_t TRAP_VECTOR  = 32'h0000_0100
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     stall_i,
  input  logic     irq_i,
  input  word_t    instruction_i,
  input  word_t    mem_data_i,
  output word_t    instruction_address_o,
  output logic     mem_operation_enable_o,
  output byte_en_t mem_write_enable_o,
  output word_t    mem_address_o,
  output word_t    mem_data_o,
  output logic     interrupt_ack_o
);

  ////////////////////////////////////////
  // Internal signals
  ////////////////////////////////////////

  // Control commands
  logic latch_instr;
  logic pc_advance;
  logic pc_jump;
  logic pc_trap;
  logic pc_return;
  logic reg_write;
  logic [1:0] wb_sel;

  // Decode outputs
  instr_class_e instr_class;
  alu_op_e  alu_op;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    imm;
  logic     use_imm;

  // Datapath
  word_t pc;
  word_t link;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;
  word_t target;
  logic  branch_taken;
  word_t wb_data;

  core_control u_control (
    .clk                    (clk),
    .rst_n_i                (rst_n_i),
    .stall_i                (stall_i),
    .irq_i                  (irq_i),
    .instr_class_i          (instr_class),
    .branch_taken_i         (branch_taken),
    .latch_instr_o          (latch_instr),
    .pc_advance_o           (pc_advance),
    .pc_jump_o              (pc_jump),
    .pc_trap_o              (pc_trap),
    .pc_return_o            (pc_return),
    .reg_write_o            (reg_write),
    .wb_sel_o               (wb_sel),
    .mem_operation_enable_o (mem_operation_enable_o),
    .mem_write_enable_o     (mem_write_enable_o),
    .interrupt_ack_o        (interrupt_ack_o)
  );

  pc_unit #(
    .RESET_VECTOR (RESET_VECTOR),
    .TRAP_VECTOR  (TRAP_VECTOR)
  ) u_pc (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .stall_i   (stall_i),
    .advance_i (pc_advance),
    .jump_i    (pc_jump),
    .trap_i    (pc_trap),
    .return_i  (pc_return),
    .target_i  (target),
    .pc_o      (pc),
    .link_o    (link)
  );

  instr_decoder u_decoder (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .latch_i       (latch_instr),
    .instruction_i (instruction_i),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .rd_o          (rd),
    .imm_o         (imm),
    .alu_op_o      (alu_op),
    .instr_class_o (instr_class),
    .use_imm_o     (use_imm)
  );

  reg_bank u_regs (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .write_i (reg_write),
    .rs1_i   (rs1),
    .rs2_i   (rs2),
    .rd_i    (rd),
    .data_i  (wb_data),
    .data1_o (rs1_data),
    .data2_o (rs2_data)
  );

  alu_unit u_alu (
    .op_i           (alu_op),
    .instr_class_i  (instr_class),
    .a_i            (rs1_data),
    .b_i            (rs2_data),
    .imm_i          (imm),
    .pc_i           (pc),
    .use_imm_i      (use_imm),
    .result_o       (alu_result),
    .target_o       (target),
    .branch_taken_o (branch_taken)
  );

  ////////////////////////////////////////
  // Write-back and memory ports
  ////////////////////////////////////////

  always_comb begin
    case (wb_sel)
      WB_LOAD: wb_data = mem_data_i;
      WB_LINK: wb_data = link;
      default: wb_data = alu_result;
    endcase
  end

  // Effective address from the ALU, store data straight from rs2
  assign instruction_address_o = pc;
  assign mem_address_o         = alu_result;
  assign mem_data_o            = rs2_data;

endmodule

// File: tb.f
+incdir+include
design/rs_core_pkg.sv
design/pc_unit.sv
design/instr_decoder.sv
design/reg_bank.sv
design/alu_unit.sv
design/core_control.sv
design/rs_core_top.sv
tests/tb_core.sv

// File: include/tb_program.svh
// Test program, data seed and expected store trace, included inside the testbench module
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Main program from address zero, ends in a self loop
localparam int PROG_WORDS = 27;
localparam logic [31:0] PROG_IMAGE [0:PROG_WORDS-1] = '{
  32'h40002083, 32'h40402103,                             // lw x1, lw x2
  32'h002081B3, 32'h50302023, 32'h40208233, 32'h50402223, // add, sub
  32'h0020F2B3, 32'h50502423, 32'h0020E333, 32'h50602623, // and, or
  32'h0020C3B3, 32'h50702823, 32'hFFB08413, 32'h50802A23, // xor, addi -5
  32'hABCDE4B7, 32'h50902C23,                             // lui
  32'h40802503, 32'h00750513, 32'h50A02E23,               // load, add 7, store
  32'h00108463, 32'h52102023,                             // beq taken, skipped sw
  32'h00109463, 32'h52202223,                             // bne not taken, marker
  32'h008005EF, 32'h52102423, 32'h52B02623,               // jal x11, skipped, link
  32'h0000006F
};

// Handler at the trap vector, stores a marker then MRET
localparam logic [31:0] HANDLER_BASE = 32'h0000_0100;
localparam int HANDLER_WORDS = 3;
localparam logic [31:0] HANDLER_IMAGE [0:HANDLER_WORDS-1] = '{
  32'h05A00613, 32'h52C02823, 32'h30200073
};

// Data memory seed, operand A, operand B and the load word
localparam logic [31:0] DATA_BASE = 32'h0000_0400;
localparam logic [31:0] DATA_SEED [0:2] = '{32'h12345678, 32'h0F0F00FF, 32'h00000ABC};
localparam logic [31:0] LOAD_INCREMENT = 32'd7;

// Store addresses of a run without interrupt
localparam int EXP_STORES = 10;
localparam logic [31:0] EXP_STORE_ADDR [0:EXP_STORES-1] = '{
  32'h500, 32'h504, 32'h508, 32'h50C, 32'h510,
  32'h514, 32'h518, 32'h51C, 32'h524, 32'h52C
};

// Slots that a taken branch or JAL must skip
localparam logic [31:0] SKIPPED_ADDR [0:1] = '{32'h520, 32'h528};

// Handler marker
localparam logic [31:0] IRQ_MARKER_ADDR = 32'h530;
localparam logic [31:0] IRQ_MARKER_DATA = 32'h0000005A;

`endif

// File: tests/tb_core.sv
// Testbench for the multicycle core; runs the test program plain, under random stalls and with an interrupt
`timescale 1ns/10ps

module tb_core
  import rs_core_pkg::*;
();

  `include "tb_program.svh"

  localparam int    CLK_PERIOD   = 8;
  localparam int    RESET_CYCLES = 8;
  localparam word_t RESET_VECTOR = 32'h0000_0000;
  localparam word_t TRAP_VECTOR  = HANDLER_BASE;

  // Immediates written into the ADDI and LUI of the program
  localparam word_t      ADDI_IMM = 32'hFFFF_FFFB;
  localparam logic [19:0] LUI_IMM = 20'hABCDE;

  // Slots of the expected trace
  localparam int ALU_LAST  = 6;
  localparam int LOAD_SLOT = 7;

  localparam int    IMEM_WORDS = 256;
  localparam int    DMEM_WORDS = 512;
  localparam word_t END_ADDR   = (PROG_WORDS - 1) * 4;

  // Cycle budgets, at most 4 cycles per instruction
  localparam int RUN_LIMIT       = PROG_WORDS * 4;
  localparam int STALL_MARGIN    = 2 * RUN_LIMIT;
  localparam int IRQ_MARGIN      = (HANDLER_WORDS + 1) * 4;
  localparam int WATCHDOG_CYCLES = 3 * (RUN_LIMIT + RESET_CYCLES + 2) + STALL_MARGIN + IRQ_MARGIN;

  logic     clk;
  logic     rst_n;
  logic     stall;
  logic     irq;
  word_t    instruction;
  word_t    mem_rdata;
  word_t    instr_addr;
  logic     mem_en;
  byte_en_t mem_we;
  word_t    mem_addr;
  word_t    mem_wdata;
  logic     irq_ack;

  // Memory models
  word_t imem [0:IMEM_WORDS-1];
  word_t dmem [0:DMEM_WORDS-1];

  // Bus traces from the monitor
  word_t store_addr_q [$];
  word_t store_data_q [$];
  word_t load_addr_q  [$];
  word_t ref_addr_q   [$];
  word_t ref_data_q   [$];
  int    ack_count;

  word_t exp_addr [0:EXP_STORES-1];
  word_t exp_data [0:EXP_STORES-1];

  integer seed;
  logic   stall_enable;
  string  current_test;
  int     error_count;
  int     test_errors;
  int     tests_run;
  int     tests_failed;

  rs_core_top #(
    .RESET_VECTOR (RESET_VECTOR),
    .TRAP_VECTOR  (TRAP_VECTOR)
  ) DUT (
    .clk                    (clk),
    .rst_n_i                (rst_n),
    .stall_i                (stall),
    .irq_i                  (irq),
    .instruction_i          (instruction),
    .mem_data_i             (mem_rdata),
    .instruction_address_o  (instr_addr),
    .mem_operation_enable_o (mem_en),
    .mem_write_enable_o     (mem_we),
    .mem_address_o          (mem_addr),
    .mem_data_o             (mem_wdata),
    .interrupt_ack_o        (irq_ack)
  );

  // Both memories answer in the same cycle
  assign instruction = imem[instr_addr[9:2]];
  assign mem_rdata   = dmem[mem_addr[10:2]];

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Stall pulses and bus monitor
  ////////////////////////////////////////

  initial begin
    seed  = 32'h5a1d;
    stall = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      // About one cycle in four
      if (stall_enable) begin
        stall = (($random(seed) & 3) == 0);
      end else begin
        stall = 1'b0;
      end
    end
  end

  // Sole writer of memories and traces, sampled mid-cycle
  initial begin
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        load_memories();
        store_addr_q.delete();
        store_data_q.delete();
        load_addr_q.delete();
        ack_count = 0;
      end else if (!stall) begin
        if (mem_we == 4'hF) begin
          dmem[mem_addr[10:2]] = mem_wdata;
          store_addr_q.push_back(mem_addr);
          store_data_q.push_back(mem_wdata);
        end else if (mem_en) begin
          load_addr_q.push_back(mem_addr);
        end
        if (irq_ack) begin
          ack_count++;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Bus assertions
  ////////////////////////////////////////

  a_trap_fetch: assert property (@(posedge clk) disable iff (!rst_n)
    irq_ack |=> (instr_addr == TRAP_VECTOR))
    else flag_error("fetch after the interrupt acknowledge is not at the trap vector");

  // Write strobe is all or nothing, and only with the enable
  a_full_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_we != 4'h0) |-> (mem_we == 4'hF && mem_en))
    else flag_error("partial write strobe or write strobe without memory enable");

  a_load_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_en && mem_we == 4'h0)
      |-> (mem_addr >= DATA_BASE && mem_addr < DATA_BASE + 4 * $size(DATA_SEED)))
    else flag_error("read access outside the seeded data words");

  // Slots behind a taken BEQ or the JAL
  a_no_skipped_store: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_we == 4'hF) |-> !(mem_addr == SKIPPED_ADDR[0] || mem_addr == SKIPPED_ADDR[1]))
    else flag_error("store from a skipped slot reached the data port");

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic load_memories;
    word_t addr;
    int    i;
    // addi x0, x0, imm with the word address as imm
    for (i = 0; i < IMEM_WORDS; i++) begin
      addr    = i * 4;
      imem[i] = {2'b00, addr[9:0], 20'h00013};
    end
    for (i = 0; i < PROG_WORDS; i++) begin
      imem[i] = PROG_IMAGE[i];
    end
    for (i = 0; i < HANDLER_WORDS; i++) begin
      imem[HANDLER_BASE[9:2] + i] = HANDLER_IMAGE[i];
    end
    for (i = 0; i < DMEM_WORDS; i++) begin
      addr    = i * 4;
      dmem[i] = addr ^ 32'hD00D_0000;
    end
    for (i = 0; i < $size(DATA_SEED); i++) begin
      dmem[DATA_BASE[10:2] + i] = DATA_SEED[i];
    end
  endtask

  task automatic count_error;
    test_errors++;
    error_count++;
  endtask

  task automatic flag_error(input string msg);
    $display("ERROR in %s: %s", current_test, msg);
    count_error();
  endtask

  task automatic compare_word(input string name, input word_t expected, input word_t actual);
    assert (actual === expected) else begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      count_error();
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("%s passed", name);
    end else begin
      tests_failed++;
      $display("%s failed with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  // Address of the linking JAL, major opcode 1101111 with rd nonzero
  function automatic word_t find_jal_address();
    word_t addr;
    int    i;
    addr = '0;
    for (i = PROG_WORDS - 1; i >= 0; i--) begin
      if (PROG_IMAGE[i][6:0] == 7'b1101111 && PROG_IMAGE[i][11:7] != 5'd0) begin
        addr = i * 4;
      end
    end
    return addr;
  endfunction

  // RISC-V results on the seeded operands
  task automatic build_expected;
    word_t a;
    word_t b;
    int    i;
    a = DATA_SEED[0];
    b = DATA_SEED[1];
    for (i = 0; i < EXP_STORES; i++) begin
      exp_addr[i] = EXP_STORE_ADDR[i];
    end
    exp_data[0] = a + b;
    exp_data[1] = a - b;
    exp_data[2] = a & b;
    exp_data[3] = a | b;
    exp_data[4] = a ^ b;
    exp_data[5] = a + ADDI_IMM;
    exp_data[6] = {LUI_IMM, 12'h000};
    exp_data[7] = DATA_SEED[2] + LOAD_INCREMENT;
    // Marker after the not-taken BNE stores x2
    exp_data[8] = b;
    exp_data[9] = find_jal_address() + 32'd4;
  endtask

  task automatic check_idle_outputs;
    compare_word(current_test, RESET_VECTOR, instr_addr);
    compare_word(current_test, 32'd0, {31'd0, mem_en});
    compare_word(current_test, 32'd0, {28'd0, mem_we});
    compare_word(current_test, 32'd0, {31'd0, irq_ack});
  endtask

  task automatic apply_reset;
    int i;
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    irq   = 1'b0;
    for (i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      check_idle_outputs();
    end
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    // First cycle out of reset
    @(negedge clk);
    check_idle_outputs();
  endtask

  // Program ends in a self loop at its last word
  task automatic wait_for_end(input int limit);
    int cycles;
    cycles = 0;
    while (instr_addr !== END_ADDR && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (instr_addr !== END_ADDR) begin
      flag_error("program did not reach its end loop in time");
    end
    @(posedge clk);
  endtask

  task automatic compare_stores(input string name, input int first, input int last);
    int i;
    for (i = first; i <= last; i++) begin
      if (i < store_addr_q.size()) begin
        compare_word(name, exp_addr[i], store_addr_q[i]);
        compare_word(name, exp_data[i], store_data_q[i]);
      end else begin
        flag_error($sformatf("store %0d never appeared", i));
      end
    end
  endtask

  // Operand A, operand B, then the load word
  task automatic check_loads;
    int i;
    compare_word("load_use", $size(DATA_SEED), load_addr_q.size());
    for (i = 0; i < load_addr_q.size() && i < $size(DATA_SEED); i++) begin
      compare_word("load_use", DATA_BASE + 4 * i, load_addr_q[i]);
    end
  endtask

  task automatic compare_with_reference;
    int i;
    compare_word("stall", ref_addr_q.size(), store_addr_q.size());
    for (i = 0; i < store_addr_q.size() && i < ref_addr_q.size(); i++) begin
      compare_word("stall", ref_addr_q[i], store_addr_q[i]);
      compare_word("stall", ref_data_q[i], store_data_q[i]);
    end
  endtask

  task automatic run_interrupt;
    int    cycles;
    int    markers;
    int    i;
    word_t main_addr [$];
    word_t main_data [$];
    // Raise irq after four stores
    cycles = 0;
    while (store_addr_q.size() < 4 && cycles < RUN_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    #1;
    irq    = 1'b1;
    cycles = 0;
    while (irq_ack !== 1'b1 && cycles < IRQ_MARGIN) begin
      @(negedge clk);
      cycles++;
    end
    if (irq_ack !== 1'b1) begin
      flag_error("no interrupt acknowledge after irq was raised");
    end
    @(posedge clk);
    #1;
    irq = 1'b0;
    @(negedge clk);
    compare_word("interrupt", TRAP_VECTOR, instr_addr);
    wait_for_end(RUN_LIMIT + IRQ_MARGIN);
    // Split the handler marker from the main trace
    markers = 0;
    for (i = 0; i < store_addr_q.size(); i++) begin
      if (store_addr_q[i] == IRQ_MARKER_ADDR) begin
        markers++;
        compare_word("interrupt", IRQ_MARKER_DATA, store_data_q[i]);
      end else begin
        main_addr.push_back(store_addr_q[i]);
        main_data.push_back(store_data_q[i]);
      end
    end
    compare_word("interrupt", 32'd1, ack_count);
    compare_word("interrupt", 32'd1, markers);
    compare_word("interrupt", EXP_STORES, main_addr.size());
    for (i = 0; i < main_addr.size() && i < EXP_STORES; i++) begin
      compare_word("interrupt", exp_addr[i], main_addr[i]);
      compare_word("interrupt", exp_data[i], main_data[i]);
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    irq          = 1'b0;
    stall_enable = 1'b0;
    error_count  = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    current_test = "reset_state";
    build_expected();

    apply_reset();
    finish_test("reset_state");

    // Plain run
    current_test = "alu_group";
    wait_for_end(RUN_LIMIT);
    compare_stores("alu_group", 0, ALU_LAST);
    finish_test("alu_group");

    current_test = "load_use";
    compare_stores("load_use", LOAD_SLOT, LOAD_SLOT);
    check_loads();
    finish_test("load_use");

    current_test = "control_flow";
    compare_stores("control_flow", LOAD_SLOT + 1, EXP_STORES - 1);
    compare_word("control_flow", EXP_STORES, store_addr_q.size());
    finish_test("control_flow");
    ref_addr_q = store_addr_q;
    ref_data_q = store_data_q;

    // Same program under random stalls
    current_test = "stall";
    apply_reset();
    stall_enable = 1'b1;
    wait_for_end(RUN_LIMIT + STALL_MARGIN);
    stall_enable = 1'b0;
    compare_with_reference();
    finish_test("stall");

    current_test = "interrupt";
    apply_reset();
    run_interrupt();
    finish_test("interrupt");

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Watchdog over all runs
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule
